// File: hdl/agenPkg.sv
`default_nettype none

package agenPkg;

   localparam int ADDR_W = 10;    // byte address
   localparam int PERIOD_W = 8;
   localparam int DELAY_W = 16;

   // 32-bit words, so strides are scaled by four
   localparam int BYTE_OFF_W = 2;

   // loop shape is shared by both sides, the pattern fields are per side
   typedef struct packed {
      logic [ADDR_W-1:0] iterations;
      logic [PERIOD_W-1:0] period;
      logic [PERIOD_W-1:0] duty;
      logic [DELAY_W-1:0] delay;
      logic [ADDR_W-1:0] start;
      logic signed [ADDR_W-1:0] shift;    // word step at the end of a period
      logic signed [ADDR_W-1:0] incr;     // word step inside the duty window
   } agCfg_t;

   typedef enum logic [3:0] {
      ITER = 4'd0,
      PERIOD = 4'd1,
      DUTY = 4'd2,
      DELAY = 4'd3,
      RD_START = 4'd4,
      RD_SHIFT = 4'd5,
      RD_INCR = 4'd6,
      WR_START = 4'd7,
      WR_SHIFT = 4'd8,
      WR_INCR = 4'd9
   } cfgIdx_e;

   // host register write strobe, the data is truncated to the field width
   typedef struct packed {
      logic en;
      cfgIdx_e idx;
      logic [15:0] data;
   } cfgWrite_t;

endpackage

`default_nettype wire

// File: hdl/memPkg.sv
`default_nettype none

package memPkg;

   localparam int DATA_W = 32;

   // word index into the scratchpad, the byte offset is dropped
   localparam int WORD_IDX_W = agenPkg::ADDR_W - agenPkg::BYTE_OFF_W;

   // host request, a read when we is low
   // the read word comes back one cycle later
   typedef struct packed {
      logic en;
      logic we;
      logic [WORD_IDX_W-1:0] wordIdx;
      logic [DATA_W-1:0] wdata;
   } hostReq_t;

endpackage

`default_nettype wire

// File: hdl/streamCfgRegs.sv
`default_nettype none

module streamCfgRegs (
   input  logic clk,
   input  logic rst,
   input  agenPkg::cfgWrite_t cfgWr,
   input  logic idle,
   output agenPkg::agCfg_t rdCfg,
   output agenPkg::agCfg_t wrCfg
);

   logic [agenPkg::ADDR_W-1:0] iterReg;
   logic [agenPkg::PERIOD_W-1:0] periodReg;
   logic [agenPkg::PERIOD_W-1:0] dutyReg;
   logic [agenPkg::DELAY_W-1:0] delayReg;
   logic [agenPkg::ADDR_W-1:0] rdStart;
   logic signed [agenPkg::ADDR_W-1:0] rdShift;
   logic signed [agenPkg::ADDR_W-1:0] rdIncr;
   logic [agenPkg::ADDR_W-1:0] wrStart;
   logic signed [agenPkg::ADDR_W-1:0] wrShift;
   logic signed [agenPkg::ADDR_W-1:0] wrIncr;

   // a copy in progress keeps its shape, so writes are only taken while idle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         iterReg <= '0;
         periodReg <= '0;
         dutyReg <= '0;
         delayReg <= '0;
         rdStart <= '0;
         rdShift <= '0;
         rdIncr <= '0;
         wrStart <= '0;
         wrShift <= '0;
         wrIncr <= '0;
      end else if (cfgWr.en && idle) begin
         case (cfgWr.idx)
            agenPkg::ITER: iterReg <= cfgWr.data[agenPkg::ADDR_W-1:0];
            agenPkg::PERIOD: periodReg <= cfgWr.data[agenPkg::PERIOD_W-1:0];
            agenPkg::DUTY: dutyReg <= cfgWr.data[agenPkg::PERIOD_W-1:0];
            agenPkg::DELAY: delayReg <= cfgWr.data[agenPkg::DELAY_W-1:0];
            agenPkg::RD_START: rdStart <= cfgWr.data[agenPkg::ADDR_W-1:0];
            agenPkg::RD_SHIFT: rdShift <= signed'(cfgWr.data[agenPkg::ADDR_W-1:0]);
            agenPkg::RD_INCR: rdIncr <= signed'(cfgWr.data[agenPkg::ADDR_W-1:0]);
            agenPkg::WR_START: wrStart <= cfgWr.data[agenPkg::ADDR_W-1:0];
            agenPkg::WR_SHIFT: wrShift <= signed'(cfgWr.data[agenPkg::ADDR_W-1:0]);
            agenPkg::WR_INCR: wrIncr <= signed'(cfgWr.data[agenPkg::ADDR_W-1:0]);
            default: ;    // unmapped indexes are dropped
         endcase
      end
   end

   always_comb begin
      rdCfg.iterations = iterReg;
      rdCfg.period = periodReg;
      rdCfg.duty = dutyReg;
      rdCfg.delay = delayReg;
      rdCfg.start = rdStart;
      rdCfg.shift = rdShift;
      rdCfg.incr = rdIncr;

      // destination follows the same loop shape
      wrCfg.iterations = iterReg;
      wrCfg.period = periodReg;
      wrCfg.duty = dutyReg;
      wrCfg.delay = delayReg;
      wrCfg.start = wrStart;
      wrCfg.shift = wrShift;
      wrCfg.incr = wrIncr;
   end

endmodule

`default_nettype wire

// File: hdl/stridedAddrGen.sv
`default_nettype none

module stridedAddrGen (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  agenPkg::agCfg_t cfg,
   output logic valid,
   input  logic ready,
   output logic [agenPkg::ADDR_W-1:0] addr,
   output logic done
);

   logic [agenPkg::DELAY_W-1:0] delayCnt;
   logic [agenPkg::PERIOD_W-1:0] perCnt;
   logic [agenPkg::ADDR_W-1:0] iterCnt;
   logic perLast;
   logic iterLast;
   logic xfer;

   // a period or iteration count of zero behaves like one
   assign perLast = ({1'b0, perCnt} + 1'b1) >= {1'b0, cfg.period};
   assign iterLast = ({1'b0, iterCnt} + 1'b1) >= {1'b0, cfg.iterations};
   assign xfer = valid && ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delayCnt <= '0;
         perCnt <= '0;
         iterCnt <= '0;
         addr <= '0;
         valid <= 1'b0;
         done <= 1'b1;
      end else if (run) begin
         delayCnt <= cfg.delay;
         perCnt <= '0;
         iterCnt <= '0;
         addr <= cfg.start;
         valid <= (cfg.delay == '0);
         done <= 1'b0;
      end else if (delayCnt != '0) begin
         delayCnt <= delayCnt - 1'b1;
         // the count is nonzero here, so this is the step from one to zero
         valid <= (delayCnt[agenPkg::DELAY_W-1:1] == '0);
      end else if (xfer) begin
         if (perLast) begin
            perCnt <= '0;
            if (iterLast) begin
               iterCnt <= '0;
               valid <= 1'b0;
               done <= 1'b1;
            end else begin
               iterCnt <= iterCnt + 1'b1;
               addr <= addr + (cfg.shift << agenPkg::BYTE_OFF_W);    // wraps at ADDR_W
            end
         end else begin
            perCnt <= perCnt + 1'b1;
            if (perCnt < cfg.duty) begin
               addr <= addr + (cfg.incr << agenPkg::BYTE_OFF_W);
            end
         end
      end
   end

   // the consumer may sample addr late, so a stalled address must hold
   addrHold: assert property (@(posedge clk) disable iff (rst)
      valid && !ready |=> $stable(addr));

   // restarting mid sequence would drop addresses the engine still expects
   runWhenDone: assert property (@(posedge clk) disable iff (rst)
      run |-> done);

endmodule

`default_nettype wire

// File: hdl/scratchRam.sv
`default_nettype none

module scratchRam #(
   parameter int DEPTH = 256
) (
   input  logic clk,
   input  logic rdEn,
   input  logic [memPkg::WORD_IDX_W-1:0] rdIdx,
   output logic [memPkg::DATA_W-1:0] rdData,
   input  logic wrEn,
   input  logic [memPkg::WORD_IDX_W-1:0] wrIdx,
   input  logic [memPkg::DATA_W-1:0] wrData
);

   logic [memPkg::DATA_W-1:0] mem [DEPTH];

   // read and write share one process, so a same-address read sees the old word
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rdData <= mem[rdIdx];
      end
      if (wrEn) begin
         mem[wrIdx] <= wrData;
      end
   end

endmodule

`default_nettype wire

// File: hdl/copyEngine.sv
`default_nettype none

module copyEngine (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  memPkg::hostReq_t host,
   input  logic srcValid,
   input  logic [agenPkg::ADDR_W-1:0] srcAddr,
   output logic srcReady,
   input  logic srcDone,
   input  logic dstValid,
   input  logic [agenPkg::ADDR_W-1:0] dstAddr,
   output logic dstReady,
   input  logic dstDone,
   output logic rdEn,
   output logic [memPkg::WORD_IDX_W-1:0] rdIdx,
   input  logic [memPkg::DATA_W-1:0] rdData,
   output logic wrEn,
   output logic [memPkg::WORD_IDX_W-1:0] wrIdx,
   output logic [memPkg::DATA_W-1:0] wrData,
   output logic done
);

   logic busy;
   logic inFlight;    // a source read was issued on the previous edge
   logic [1:0] bufCount;
   logic bufWrPtr;
   logic bufRdPtr;
   logic [memPkg::DATA_W-1:0] bufData [2];
   logic srcXfer;
   logic dstXfer;
   logic [memPkg::WORD_IDX_W-1:0] srcWord;
   logic [memPkg::WORD_IDX_W-1:0] dstWord;

   assign srcWord = srcAddr[agenPkg::ADDR_W-1:agenPkg::BYTE_OFF_W];
   assign dstWord = dstAddr[agenPkg::ADDR_W-1:agenPkg::BYTE_OFF_W];

   // a read in flight already owns a buffer slot
   assign srcReady = ({1'b0, inFlight} + bufCount) < 2'd2;
   assign dstReady = (bufCount != 2'd0);
   assign srcXfer = srcValid && srcReady;
   assign dstXfer = dstValid && dstReady;

   // port A serves the host when idle and the source side during a copy
   assign rdEn = busy ? srcXfer : (host.en && !host.we);
   assign rdIdx = busy ? srcWord : host.wordIdx;
   assign wrEn = busy ? dstXfer : (host.en && host.we);
   assign wrIdx = busy ? dstWord : host.wordIdx;
   assign wrData = busy ? bufData[bufRdPtr] : host.wdata;
   assign done = !busy;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         inFlight <= 1'b0;
         bufCount <= '0;
         bufWrPtr <= 1'b0;
         bufRdPtr <= 1'b0;
      end else begin
         if (run) begin
            busy <= 1'b1;
         end else if (srcDone && dstDone && !inFlight && bufCount == 2'd0) begin
            busy <= 1'b0;
         end
         inFlight <= srcXfer;
         bufCount <= bufCount + {1'b0, inFlight} - {1'b0, dstXfer};
         if (inFlight) bufWrPtr <= !bufWrPtr;
         if (dstXfer) bufRdPtr <= !bufRdPtr;
      end
   end

   always_ff @(posedge clk) begin
      if (inFlight) begin
         bufData[bufWrPtr] <= rdData;
      end
   end

   // host access during a copy is ignored
   hostWhenIdle: assert property (@(posedge clk) disable iff (rst)
      host.en |-> done);

   // both generators stay quiet until the copy they belong to has started
   validOnlyBusy: assert property (@(posedge clk) disable iff (rst)
      !busy |-> !srcValid && !dstValid);

endmodule

`default_nettype wire

// File: hdl/stridedCopyTop.sv
`default_nettype none

module stridedCopyTop (
   input  logic clk,
   input  logic rst,
   input  agenPkg::cfgWrite_t cfgWr,
   input  logic run,
   input  memPkg::hostReq_t host,
   output logic [memPkg::DATA_W-1:0] hostRdata,
   output logic done
);

   agenPkg::agCfg_t rdCfg;
   agenPkg::agCfg_t wrCfg;

   logic srcValid;
   logic srcReady;
   logic srcDone;
   logic [agenPkg::ADDR_W-1:0] srcAddr;
   logic dstValid;
   logic dstReady;
   logic dstDone;
   logic [agenPkg::ADDR_W-1:0] dstAddr;

   logic ramRdEn;
   logic [memPkg::WORD_IDX_W-1:0] ramRdIdx;
   logic [memPkg::DATA_W-1:0] ramRdData;
   logic ramWrEn;
   logic [memPkg::WORD_IDX_W-1:0] ramWrIdx;
   logic [memPkg::DATA_W-1:0] ramWrData;

   streamCfgRegs u_regs (
      .clk   (clk),
      .rst   (rst),
      .cfgWr (cfgWr),
      .idle  (done),
      .rdCfg (rdCfg),
      .wrCfg (wrCfg)
   );

   stridedAddrGen u_srcGen (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (rdCfg),
      .valid (srcValid),
      .ready (srcReady),
      .addr  (srcAddr),
      .done  (srcDone)
   );

   stridedAddrGen u_dstGen (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (wrCfg),
      .valid (dstValid),
      .ready (dstReady),
      .addr  (dstAddr),
      .done  (dstDone)
   );

   copyEngine u_engine (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .host     (host),
      .srcValid (srcValid),
      .srcAddr  (srcAddr),
      .srcReady (srcReady),
      .srcDone  (srcDone),
      .dstValid (dstValid),
      .dstAddr  (dstAddr),
      .dstReady (dstReady),
      .dstDone  (dstDone),
      .rdEn     (ramRdEn),
      .rdIdx    (ramRdIdx),
      .rdData   (ramRdData),
      .wrEn     (ramWrEn),
      .wrIdx    (ramWrIdx),
      .wrData   (ramWrData),
      .done     (done)
   );

   scratchRam #(
      .DEPTH (256)
   ) u_ram (
      .clk    (clk),
      .rdEn   (ramRdEn),
      .rdIdx  (ramRdIdx),
      .rdData (ramRdData),
      .wrEn   (ramWrEn),
      .wrIdx  (ramWrIdx),
      .wrData (ramWrData)
   );

   assign hostRdata = ramRdData;    // also shows copy reads while busy

endmodule

`default_nettype wire

// File: verif/stridedCopyTb.sv
`default_nettype none

module stridedCopyTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_TESTS = 20;
   localparam int WORDS = 256;
   localparam int MAX_N = 256;
   // preload, readback and two runs with the longest delay at four cycles per transfer
   localparam int TEST_CYCLES = 2 * WORDS + 2 * (255 + 4 * WORDS) + WORDS;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 1000;

   logic clk;
   logic rst;
   agenPkg::cfgWrite_t cfgWr;
   logic run;
   memPkg::hostReq_t host;
   logic [memPkg::DATA_W-1:0] hostRdata;
   logic done;

   logic [31:0] lfsrState = 32'hc972_2872;
   int errCount = 0;
   int checkCount = 0;
   int cycleCount = 0;

   agenPkg::agCfg_t srcCfg;
   agenPkg::agCfg_t dstCfg;
   int seqLen;    // emissions per side, equal for both since the loop shape is shared
   logic [agenPkg::ADDR_W-1:0] srcAddrs [MAX_N];
   logic [agenPkg::ADDR_W-1:0] dstAddrs [MAX_N];
   logic [memPkg::DATA_W-1:0] modelMem [WORDS];
   bit srcUsed [WORDS];

   stridedCopyTop u_dut (
      .clk       (clk),
      .rst       (rst),
      .cfgWr     (cfgWr),
      .run       (run),
      .host      (host),
      .hostRdata (hostRdata),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles, a copy never finished", cycleCount);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1 with the feedback shifted in at bit 0
   function automatic logic [31:0] stepLfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      int i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsrState = stepLfsr(lfsrState);
         r = {r[30:0], lfsrState[0]};
      end
      return r;
   endfunction

   function automatic logic [memPkg::WORD_IDX_W-1:0] wordOf(input logic [agenPkg::ADDR_W-1:0] a);
      return a[agenPkg::ADDR_W-1:2];
   endfunction

   task automatic compareValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errCount++;
         $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
      end
   endtask

   task automatic drawConfig(input int kind);
      int nPer;
      srcCfg.delay = 16'(randBits(8));
      srcCfg.start = 10'(randBits(10));
      dstCfg.start = 10'(randBits(10));
      srcCfg.iterations = 10'(1 + randBits(2));
      srcCfg.period = 8'(1 + randBits(2));
      srcCfg.duty = 8'(randBits(2));
      srcCfg.shift = 10'(randBits(10));
      srcCfg.incr = 10'(randBits(10));
      dstCfg.shift = 10'(randBits(10));
      dstCfg.incr = 10'(randBits(10));
      case (kind)
         0: begin
            srcCfg.iterations = 10'(1 + randBits(5));
            srcCfg.period = 8'd1;    // incr is never applied here
            srcCfg.duty = 8'd0;
            srcCfg.shift = 10'sd1;
            dstCfg.shift = 10'sd1;
         end
         1: begin
            nPer = 3 + int'(randBits(2));
            srcCfg.period = 8'(nPer);
            srcCfg.duty = 8'(int'(randBits(8)) % (nPer - 1));    // addresses repeat
            srcCfg.shift = 10'(randBits(3));
            dstCfg.shift = 10'(randBits(3));
            srcCfg.incr = 10'(int'(randBits(3)) - 4);
            dstCfg.incr = 10'(int'(randBits(3)) - 4);
         end
         2: begin
            srcCfg.iterations = 10'(1 + randBits(3));
            // source climbs past the top, destination falls below zero
            srcCfg.start = 10'(1023 - int'(randBits(6)));
            srcCfg.shift = 10'(1 + randBits(4));
            srcCfg.incr = 10'(-1 - int'(randBits(2)));
            dstCfg.start = 10'(randBits(6));
            dstCfg.shift = 10'(-1 - int'(randBits(4)));
            dstCfg.incr = 10'(-1 - int'(randBits(2)));
         end
         default: ;
      endcase
      dstCfg.iterations = srcCfg.iterations;
      dstCfg.period = srcCfg.period;
      dstCfg.duty = srcCfg.duty;
      dstCfg.delay = srcCfg.delay;
   endtask

   task automatic walkPattern(input agenPkg::agCfg_t c, input bit toDst);
      logic [agenPkg::ADDR_W-1:0] a;
      int n;
      int i;
      int k;
      a = c.start;
      n = 0;
      for (i = 0; i < int'(c.iterations); i++) begin
         for (k = 0; k < int'(c.period); k++) begin
            if (toDst)
               dstAddrs[n] = a;
            else
               srcAddrs[n] = a;
            n++;
            if (k == int'(c.period) - 1)
               a = a + {c.shift[7:0], 2'b00};    // word steps become byte steps
            else if (k < int'(c.duty))
               a = a + {c.incr[7:0], 2'b00};
         end
      end
      seqLen = n;
   endtask

   task automatic findOverlap(output bit overlap);
      int n;
      overlap = 1'b0;
      for (n = 0; n < WORDS; n++) srcUsed[n] = 1'b0;
      for (n = 0; n < seqLen; n++) srcUsed[wordOf(srcAddrs[n])] = 1'b1;
      for (n = 0; n < seqLen; n++) begin
         if (srcUsed[wordOf(dstAddrs[n])]) overlap = 1'b1;
      end
   endtask

   task automatic modelCopy;
      int n;
      for (n = 0; n < seqLen; n++) begin
         modelMem[wordOf(dstAddrs[n])] = modelMem[wordOf(srcAddrs[n])];
      end
   endtask

   task automatic writeReg(input agenPkg::cfgIdx_e idx, input logic [15:0] data);
      agenPkg::cfgWrite_t w;
      w.en = 1'b1;
      w.idx = idx;
      w.data = data;
      @(posedge clk);
      cfgWr <= w;
   endtask

   task automatic programConfig;
      writeReg(agenPkg::ITER, {6'd0, srcCfg.iterations});
      writeReg(agenPkg::PERIOD, {8'd0, srcCfg.period});
      writeReg(agenPkg::DUTY, {8'd0, srcCfg.duty});
      writeReg(agenPkg::DELAY, srcCfg.delay);
      writeReg(agenPkg::RD_START, {6'd0, srcCfg.start});
      writeReg(agenPkg::RD_SHIFT, {6'd0, srcCfg.shift});
      writeReg(agenPkg::RD_INCR, {6'd0, srcCfg.incr});
      writeReg(agenPkg::WR_START, {6'd0, dstCfg.start});
      writeReg(agenPkg::WR_SHIFT, {6'd0, dstCfg.shift});
      writeReg(agenPkg::WR_INCR, {6'd0, dstCfg.incr});
   endtask

   function automatic agenPkg::cfgWrite_t junkWrite();
      agenPkg::cfgWrite_t w;
      w.en = 1'b1;
      w.idx = agenPkg::cfgIdx_e'(4'(randBits(8) % 10));
      w.data = 16'(randBits(16));
      return w;
   endfunction

   task automatic preloadRam;
      memPkg::hostReq_t req;
      int i;
      for (i = 0; i < WORDS; i++) begin
         req.en = 1'b1;
         req.we = 1'b1;
         req.wordIdx = 8'(i);
         req.wdata = randBits(32);
         modelMem[i] = req.wdata;
         @(posedge clk);
         host <= req;
      end
      @(posedge clk);
      host <= '0;
   endtask

   // reads are pipelined, word i-1 is on hostRdata while word i is requested
   task automatic readbackRam(input string what);
      memPkg::hostReq_t req;
      int i;
      for (i = 0; i <= WORDS; i++) begin
         req = '0;
         if (i < WORDS) begin
            req.en = 1'b1;
            req.wordIdx = 8'(i);
         end
         @(posedge clk);
         host <= req;
         @(negedge clk);
         if (i > 0) compareValue($sformatf("%s word %0d", what, i - 1), modelMem[i - 1], hostRdata);
      end
   endtask

   task automatic runCopy;
      @(posedge clk);
      cfgWr <= '0;
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      cfgWr <= junkWrite();    // the shortest copy still covers these three writes
      @(negedge clk);
      compareValue("done low after run", 32'd0, {31'd0, done});
      repeat (2) begin
         @(posedge clk);
         cfgWr <= junkWrite();
      end
      @(posedge clk);
      cfgWr <= '0;
      do @(negedge clk); while (!done);
   endtask

   initial begin
      bit overlap;
      int t;
      rst <= 1'b1;
      run <= 1'b0;
      cfgWr <= '0;
      host <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compareValue("done after reset", 32'd1, {31'd0, done});
      for (t = 0; t < NUM_TESTS; t++) begin
         do begin
            drawConfig(t % 4);
            walkPattern(dstCfg, 1'b1);
            walkPattern(srcCfg, 1'b0);
            findOverlap(overlap);
         end while (overlap);
         preloadRam();
         if (t == 0) readbackRam("host access");
         programConfig();
         // the second run reuses the registers that the dropped writes tried to change
         repeat (2) begin
            runCopy();
            modelCopy();
         end
         readbackRam($sformatf("test %0d kind %0d", t, t % 4));
      end
      $display("%0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
hdl/agenPkg.sv
hdl/memPkg.sv
hdl/streamCfgRegs.sv
hdl/stridedAddrGen.sv
hdl/scratchRam.sv
hdl/copyEngine.sv
hdl/stridedCopyTop.sv
verif/stridedCopyTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = stridedCopyTb
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
